// File: dv/des_search_testdata.txt
# Columns are kind, offset and value. W writes, R reads and compares, X writes expecting pslverr
# P offset mask cycles polls STATUS, C index checks CT_LO and CT_HI against DES of region and index
R 04 00000000
R 24 00000000
R 30 00000000
R 28 00000000
R 2C 00000000
R 08 00000000
R 0C 00000000
R 10 00000000
R 14 00000000
R 1C 00000000
R 00 00000000
W 08 A5C30F1E
W 0C 13579BDF
W 10 FFFFACE1
W 14 F00F0081
W 18 80000001
W 1C 0F0F3C3C
W 20 12488421
R 08 A5C30F1E
R 0C 13579BDF
R 10 0000ACE1
R 14 F00F0081
R 18 80000001
R 1C 0F0F3C3C
R 20 12488421
X 34
X 24
W 00 00000002
R 04 00000000
R 30 00000000
W 00 00000001
P 04 00000004 100
R 30 00000001
C 00
W 00 00000002
P 04 00000004 100
R 30 00000002
C 01
W 00 00000002
P 04 00000004 100
R 30 00000003
C 02
W 00 00000002
P 04 00000004 100
R 30 00000004
C 03
W 00 00000000
R 04 00000004
W 00 00000003
R 04 00000000
R 24 00000000
R 30 00000000
# Sweep masks select region bit 31 and index bits 7 and 0, so half the plaintexts hit
W 14 00000081
W 18 80000000
W 1C 00000000
W 20 00000000
W 00 00000000
P 04 00000002 5000
R 30 00000100
R 24 00000080
C FF
W 00 00000002
R 04 00000002
R 30 00000100
W 00 00000000
R 04 00000001
W 00 00000003
R 04 00000000
R 24 00000000
R 30 00000000
W 00 00000000
P 04 00000002 5000
R 30 00000100
R 24 00000080
C FF

// File: all.f
common/des_pkg.sv
des_core/des_round_core.sv
logic/bias_tally.sv
logic/search_regs.sv
logic/search_ctrl.sv
logic/des_search_top.sv
dv/des_search_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= des_search_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/des_search_tb.sv
`timescale 1ns/1ps

module des_search_tb import des_pkg::*; ();

    localparam int    CLK_HALF    = 2;    // 4 ns period
    localparam int    DRIVE_DLY   = 1;
    localparam int    RST_CYCLES  = 16;
    localparam int    APB_TIMEOUT = 16;
    localparam string DATA_FILE   = "dv/des_search_testdata.txt";

    // Reference S-boxes, one word per box, row 0 in the top 64 bits
    localparam logic [255:0] SBOX_REF [8] = '{
        256'hE4D12FB83A6C59070F74E2D1A6CB953841E8D62BFC973A50FC8249175B3EA06D,
        256'hF18E6B34972DC05A3D47F28EC01A69B50E7BA4D158C6932FD8A13F42B67C05E9,
        256'hA09E63F51DC7B428D70934A6285ECBF1D6498F30B12C5AE71AD069874FE3B52C,
        256'h7DE3069A1285BC4FD8B56F03472C1AE9A690CB7DF13E52843F06A1D8945BC72E,
        256'h2C417AB6853FD0E9EB2C47D150FA3986421BAD78F9C5630EB8C71E2D6F09A453,
        256'hC1AF92680D34E75BAF427C9561DE0B389EF528C3704A1DB6432C95FABE17608D,
        256'h4B2EF08D3C975A61D0B7491AE35C2F8614BDC37EAF6805926BD814A7950FE23C,
        256'hD2846FB1A93E50C71FD8A374C56B0E927B419CE206ADF35821E74A8DFC90356B
    };

    localparam int P_REF [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    logic        clk;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          cycles = 0;
    int          checks = 0;
    logic [31:0] region_w;    // Mirror of the last region write
    logic [47:0] key_w;
    logic [63:0] in_mask_w;
    logic [63:0] out_mask_w;

    des_search_top i_des_search_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // Source bit of IP for output position i, counted from 1 at the MSB
    function automatic int ip_src(input int i);
        int row;
        int first;
        row   = i / 8;
        first = (row < 4) ? 58 + 2 * row : 57 + 2 * (row - 4);
        return first - 8 * (i % 8);
    endfunction

    // Reduced-round DES with one key in every round and no final swap
    function automatic logic [63:0] des_model(input logic [63:0] pt, input logic [47:0] key);
        logic [63:0] perm;
        logic [63:0] ct;
        logic [47:0] x;
        logic [31:0] l;
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] f;
        logic [31:0] tmp;
        logic [5:0]  six;
        int          e_bit;
        int          row;
        int          col;
        for (int i = 0; i < 64; i++) begin
            perm[63 - i] = pt[64 - ip_src(i)];
        end
        l = perm[63:32];
        r = perm[31:0];
        for (int n = 0; n < DES_ROUNDS; n++) begin
            for (int k = 0; k < 48; k++) begin
                e_bit     = (4 * (k / 6) + (k % 6) + 31) % 32;   // Wraps at both ends
                x[47 - k] = r[31 - e_bit];
            end
            x = x ^ key;
            for (int b = 0; b < 8; b++) begin
                six = x[47 - 6 * b -: 6];
                row = {six[5], six[0]};
                col = six[4:1];
                s[31 - 4 * b -: 4] = SBOX_REF[b][255 - 64 * row - 4 * col -: 4];
            end
            for (int i = 0; i < 32; i++) begin
                f[31 - i] = s[32 - P_REF[i]];
            end
            tmp = r;
            r   = l ^ f;
            l   = tmp;
        end
        perm = {l, r};
        for (int i = 0; i < 64; i++) begin
            ct[64 - ip_src(i)] = perm[63 - i];   // Inverse of IP
        end
        return ct;
    endfunction

    function automatic string status_name(input logic [31:0] mask);
        case (mask)
            32'h1:   return "busy";
            32'h2:   return "done";
            32'h4:   return "step_ready";
            default: return $sformatf("with mask 0x%08h", mask);
        endcase
    endfunction

    // One APB transfer with a random idle gap in front
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        repeat ($urandom_range(0, 3)) @(posedge clk);
        @(posedge clk);
        #(DRIVE_DLY);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #(DRIVE_DLY);
        penable = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!pready && waited < APB_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (pready) else
            fail_run($sformatf("APB slave never raised pready at offset 0x%02h", addr));
        rdata = prdata;   // Sampled mid access phase
        err   = pslverr;
        @(posedge clk);
        #(DRIVE_DLY);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_check(input logic [7:0] addr, input logic [31:0] data,
                               input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, data, rdata, err);
        assert (err == exp_err) else
            fail_run($sformatf("mismatch pslverr at offset 0x%02h expected 0x%0h actual 0x%0h",
                               addr, exp_err, err));
        checks++;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, addr, 32'h0, rdata, err);
        assert (!err) else
            fail_run($sformatf("mismatch pslverr at offset 0x%02h expected 0x0 actual 0x1", addr));
        assert (rdata == expected) else
            fail_run($sformatf("mismatch prdata at offset 0x%02h expected 0x%08h actual 0x%08h",
                               addr, expected, rdata));
        checks++;
    endtask

    task automatic poll_status(input logic [7:0] addr, input logic [31:0] mask, input int limit);
        logic [31:0] rdata;
        logic        err;
        int          start;
        start = cycles;
        apb_transfer(1'b0, addr, 32'h0, rdata, err);
        while ((rdata & mask) == 0 && cycles - start < limit) begin
            apb_transfer(1'b0, addr, 32'h0, rdata, err);
        end
        assert ((rdata & mask) != 0) else
            fail_run($sformatf("STATUS bit %s never rose within %0d cycles",
                               status_name(mask), limit));
        checks++;
    endtask

    task automatic check_ct(input logic [31:0] idx);
        logic [63:0] expected;
        expected = des_model({region_w, idx}, key_w);   // Index sits zero-extended in the low word
        read_check(REG_CT_LO, expected[31:0]);
        read_check(REG_CT_HI, expected[63:32]);
    endtask

    // Plaintexts 0 to steps-1 counted where the masked bit counts add up even
    task automatic check_hits(input logic [31:0] steps);
        logic [63:0] pt;
        logic [63:0] ct;
        logic [31:0] expected;
        expected = '0;
        for (int i = 0; i < steps; i++) begin
            pt = {region_w, 32'(i)};
            ct = des_model(pt, key_w);
            if (($countones(pt & in_mask_w) + $countones(ct & out_mask_w)) % 2 == 0) begin
                expected++;
            end
        end
        read_check(REG_HITS, expected);
    endtask

    initial begin
        int               fd;
        int               code;
        int               limit;
        logic [127:0]     kind;
        logic [8*256-1:0] rest;
        logic [7:0]       off;
        logic [31:0]      val;
        logic [31:0]      mask;
        logic             eof;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 8'h00;
        pwdata     = 32'h0;
        region_w   = 32'h0;
        key_w      = 48'h0;
        in_mask_w  = 64'h0;
        out_mask_w = 64'h0;
        eof        = 1'b0;
        void'($urandom(32'h90410376));
        fd = $fopen(DATA_FILE, "r");
        assert (fd != 0) else fail_run("could not open the stimulus data file");
        repeat (RST_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        rst_n = 1'b1;

        // Upper mask words start at zero too
        read_check(REG_MASK_IN_HI, 32'h0);
        read_check(REG_MASK_OUT_HI, 32'h0);

        while (!eof) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                eof = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(rest, fd);   // Comment line
            end else if (kind == "W") begin
                code = $fscanf(fd, "%h %h", off, val);
                assert (code == 2) else fail_run("a W line in the data file is incomplete");
                write_check(off, val, 1'b0);
                case (off)
                    REG_REGION:      region_w           = val;
                    REG_KEY_LO:      key_w[31:0]        = val;
                    REG_KEY_HI:      key_w[47:32]       = val[15:0];
                    REG_MASK_IN_LO:  in_mask_w[31:0]    = val;
                    REG_MASK_IN_HI:  in_mask_w[63:32]   = val;
                    REG_MASK_OUT_LO: out_mask_w[31:0]   = val;
                    REG_MASK_OUT_HI: out_mask_w[63:32]  = val;
                    default: ;
                endcase
            end else if (kind == "R") begin
                code = $fscanf(fd, "%h %h", off, val);
                assert (code == 2) else fail_run("an R line in the data file is incomplete");
                read_check(off, val);
            end else if (kind == "P") begin
                code = $fscanf(fd, "%h %h %d", off, mask, limit);
                assert (code == 3) else fail_run("a P line in the data file is incomplete");
                poll_status(off, mask, limit);
            end else if (kind == "X") begin
                code = $fscanf(fd, "%h", off);
                assert (code == 1) else fail_run("an X line in the data file is incomplete");
                write_check(off, 32'h0, 1'b1);
            end else if (kind == "C") begin
                code = $fscanf(fd, "%h", val);
                assert (code == 1) else fail_run("a C line in the data file is incomplete");
                check_ct(val);
                check_hits(val + 1);   // Every index up to this one has been sampled
            end else begin
                fail_run("the data file holds a line of unknown kind");
            end
        end
        $fclose(fd);

        if (checks > 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_run("the data file held no checks");
        end
    end

endmodule

// File: logic/des_search_top.sv
`timescale 1ns/1ps

module des_search_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic [31:0] region;
    logic [47:0] round_key;
    logic [63:0] mask_in;
    logic [63:0] mask_out;
    logic        cmd_start;
    logic        cmd_test;
    logic        cmd_advance;
    logic        cmd_restart;
    logic        busy;
    logic        done;
    logic        step_ready;
    logic        core_start;
    logic        core_done;
    logic [63:0] plaintext;
    logic [63:0] ciphertext;
    logic        tally_clear;
    logic        tally_sample;
    logic [31:0] hits;
    logic [31:0] count;

    search_regs i_search_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .busy        (busy),
        .done        (done),
        .step_ready  (step_ready),
        .hits        (hits),
        .count       (count),
        .ciphertext  (ciphertext),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .region      (region),
        .round_key   (round_key),
        .mask_in     (mask_in),
        .mask_out    (mask_out),
        .cmd_start   (cmd_start),
        .cmd_test    (cmd_test),
        .cmd_advance (cmd_advance),
        .cmd_restart (cmd_restart)
    );

    search_ctrl i_search_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_start    (cmd_start),
        .cmd_test     (cmd_test),
        .cmd_advance  (cmd_advance),
        .cmd_restart  (cmd_restart),
        .region       (region),
        .core_done    (core_done),
        .core_start   (core_start),
        .plaintext    (plaintext),
        .tally_clear  (tally_clear),
        .tally_sample (tally_sample),
        .busy         (busy),
        .done         (done),
        .step_ready   (step_ready)
    );

    des_round_core i_des_round_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (core_start),
        .plaintext  (plaintext),
        .round_key  (round_key),
        .done       (core_done),
        .ciphertext (ciphertext)
    );

    bias_tally i_bias_tally (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (tally_clear),
        .sample     (tally_sample),
        .plaintext  (plaintext),
        .ciphertext (ciphertext),
        .mask_in    (mask_in),
        .mask_out   (mask_out),
        .hits       (hits),
        .count      (count)
    );

endmodule

// File: logic/search_ctrl.sv
`timescale 1ns/1ps

module search_ctrl import des_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmd_start,
    input  logic        cmd_test,
    input  logic        cmd_advance,
    input  logic        cmd_restart,
    input  logic [31:0] region,
    input  logic        core_done,
    output logic        core_start,
    output logic [63:0] plaintext,
    output logic        tally_clear,
    output logic        tally_sample,
    output logic        busy,
    output logic        done,
    output logic        step_ready
);

    search_state_e         state;
    logic [SWEEP_BITS-1:0] index;
    logic                  core_busy;   // Core still working, possibly on an abandoned block
    logic                  can_start;

    assign can_start    = (state == ST_IDLE) || (state == ST_DONE);
    assign plaintext    = {region, {(32 - SWEEP_BITS){1'b0}}, index};
    assign tally_clear  = cmd_restart || (can_start && (cmd_start || cmd_test));
    assign tally_sample = core_done && !cmd_restart &&
                          (state == ST_WAIT || state == ST_TEST_WAIT);

    assign busy       = state inside {ST_LAUNCH, ST_WAIT, ST_TEST_LAUNCH, ST_TEST_WAIT};
    assign done       = (state == ST_DONE);
    assign step_ready = (state == ST_TEST_HOLD);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            index      <= '0;
            core_start <= 1'b0;
            core_busy  <= 1'b0;
        end else begin
            core_start <= 1'b0;
            if (core_start) begin
                core_busy <= 1'b1;
            end else if (core_done) begin
                core_busy <= 1'b0;
            end

            if (cmd_restart) begin
                state <= ST_IDLE;
                index <= '0;
            end else begin
                case (state)
                    ST_IDLE, ST_DONE: begin
                        if (cmd_start) begin
                            index <= '0;
                            state <= ST_LAUNCH;
                        end else if (cmd_test) begin
                            index <= '0;
                            state <= ST_TEST_LAUNCH;
                        end
                    end
                    ST_LAUNCH, ST_TEST_LAUNCH: begin
                        if (!core_busy) begin
                            core_start <= 1'b1;
                            state      <= (state == ST_LAUNCH) ? ST_WAIT : ST_TEST_WAIT;
                        end
                    end
                    ST_WAIT: begin
                        if (core_done) begin
                            if (index == SWEEP_BITS'(SWEEP_LAST)) begin
                                state <= ST_DONE;          // Last ciphertext stays in the core
                            end else begin
                                index <= index + 1'b1;
                                state <= ST_LAUNCH;
                            end
                        end
                    end
                    ST_TEST_WAIT: if (core_done) state <= ST_TEST_HOLD;
                    ST_TEST_HOLD: begin
                        if (cmd_advance) begin
                            index <= index + 1'b1;
                            state <= ST_TEST_LAUNCH;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        core_start |-> $past(state == ST_LAUNCH || state == ST_TEST_LAUNCH));

endmodule

// File: logic/search_regs.sv
`timescale 1ns/1ps

module search_regs import des_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    input  logic        busy,
    input  logic        done,
    input  logic        step_ready,
    input  logic [31:0] hits,
    input  logic [31:0] count,
    input  logic [63:0] ciphertext,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [31:0] region,
    output logic [47:0] round_key,
    output logic [63:0] mask_in,
    output logic [63:0] mask_out,
    output logic        cmd_start,
    output logic        cmd_test,
    output logic        cmd_advance,
    output logic        cmd_restart
);

    logic access;
    logic mapped;
    logic rd_only;
    logic wr_ok;

    assign access  = psel && penable;
    assign pready  = 1'b1;                           // Zero wait states
    assign pslverr = access && (!mapped || (pwrite && rd_only));
    assign wr_ok   = access && pwrite && mapped && !rd_only;

    always_comb begin
        mapped  = 1'b1;
        rd_only = 1'b0;
        prdata  = '0;
        case (paddr)
            REG_CMD:         prdata = '0;            // Write only, reads zero
            REG_STATUS: begin
                prdata  = {29'd0, step_ready, done, busy};
                rd_only = 1'b1;
            end
            REG_REGION:      prdata = region;
            REG_KEY_LO:      prdata = round_key[31:0];
            REG_KEY_HI:      prdata = {16'd0, round_key[47:32]};
            REG_MASK_IN_LO:  prdata = mask_in[31:0];
            REG_MASK_IN_HI:  prdata = mask_in[63:32];
            REG_MASK_OUT_LO: prdata = mask_out[31:0];
            REG_MASK_OUT_HI: prdata = mask_out[63:32];
            REG_HITS, REG_CT_LO, REG_CT_HI, REG_COUNT: begin
                rd_only = 1'b1;
                prdata  = (paddr == REG_HITS)  ? hits :
                          (paddr == REG_COUNT) ? count :
                          (paddr == REG_CT_LO) ? ciphertext[31:0] : ciphertext[63:32];
            end
            default:         mapped = 1'b0;
        endcase
    end

    // Configuration registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            region    <= '0;
            round_key <= '0;
            mask_in   <= '0;
            mask_out  <= '0;
        end else if (wr_ok) begin
            case (paddr)
                REG_REGION:      region           <= pwdata;
                REG_KEY_LO:      round_key[31:0]  <= pwdata;
                REG_KEY_HI:      round_key[47:32] <= pwdata[15:0];
                REG_MASK_IN_LO:  mask_in[31:0]    <= pwdata;
                REG_MASK_IN_HI:  mask_in[63:32]   <= pwdata;
                REG_MASK_OUT_LO: mask_out[31:0]   <= pwdata;
                REG_MASK_OUT_HI: mask_out[63:32]  <= pwdata;
                default: ;
            endcase
        end
    end

    // One pulse per command write, the cycle after the access phase
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {cmd_start, cmd_test, cmd_advance, cmd_restart} <= 4'b0000;
        end else begin
            {cmd_start, cmd_test, cmd_advance, cmd_restart} <= 4'b0000;
            if (wr_ok && paddr == REG_CMD) begin
                case (search_cmd_e'(pwdata[1:0]))
                    CMD_START:   cmd_start   <= 1'b1;
                    CMD_TEST:    cmd_test    <= 1'b1;
                    CMD_ADVANCE: cmd_advance <= 1'b1;
                    CMD_RESTART: cmd_restart <= 1'b1;
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({cmd_start, cmd_test, cmd_advance, cmd_restart}));

endmodule

// File: logic/bias_tally.sv
`timescale 1ns/1ps

module bias_tally (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  logic        sample,
    input  logic [63:0] plaintext,
    input  logic [63:0] ciphertext,
    input  logic [63:0] mask_in,
    input  logic [63:0] mask_out,
    output logic [31:0] hits,
    output logic [31:0] count
);

    logic bias_bit;

    // Linear approximation holds when this is zero
    assign bias_bit = ^(plaintext & mask_in) ^ ^(ciphertext & mask_out);

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            hits  <= '0;
            count <= '0;
        end else if (sample) begin
            count <= count + 1'b1;
            if (!bias_bit) begin
                hits <= hits + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(sample && clear));

endmodule

// File: des_core/des_round_core.sv
`timescale 1ns/1ps

module des_round_core import des_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [63:0] plaintext,
    input  logic [47:0] round_key,
    output logic        done,
    output logic [63:0] ciphertext
);

    logic [31:0]      l_q;
    logic [31:0]      r_q;
    logic [31:0]      r_next;
    logic [RND_W-1:0] round_cnt;
    logic             busy;
    logic             last_round;

    function automatic logic [63:0] ip_perm(input logic [63:0] din);
        logic [63:0] dout;
        for (int i = 0; i < 64; i++) begin
            dout[63-i] = din[64-IP_TABLE[i]];
        end
        return dout;
    endfunction

    function automatic logic [63:0] fp_perm(input logic [63:0] din);
        logic [63:0] dout;
        for (int i = 0; i < 64; i++) begin
            dout[63-i] = din[64-FP_TABLE[i]];
        end
        return dout;
    endfunction

    // Expansion, key mix, S-boxes, P
    function automatic logic [31:0] feistel(input logic [31:0] r, input logic [47:0] k);
        logic [47:0] x;
        logic [5:0]  six;
        logic [31:0] s_out;
        logic [31:0] f;
        for (int i = 0; i < 48; i++) begin
            x[47-i] = r[32-E_TABLE[i]];
        end
        x = x ^ k;
        for (int b = 0; b < 8; b++) begin
            six = x[47-6*b -: 6];
            s_out[31-4*b -: 4] = SBOX_TABLE[b][{six[5], six[0]}][63-4*six[4:1] -: 4];
        end
        for (int i = 0; i < 32; i++) begin
            f[31-i] = s_out[32-P_TABLE[i]];
        end
        return f;
    endfunction

    assign r_next     = l_q ^ feistel(r_q, round_key);
    assign last_round = busy && (round_cnt == RND_W'(DES_ROUNDS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            round_cnt  <= '0;
            done       <= 1'b0;
            ciphertext <= '0;
        end else begin
            done <= last_round;
            if (start) begin
                busy      <= 1'b1;
                round_cnt <= '0;
            end else if (busy) begin
                round_cnt <= round_cnt + 1'b1;
                if (last_round) begin
                    busy       <= 1'b0;
                    ciphertext <= fp_perm({r_q, r_next}); // Halves kept in place, no swap
                end
            end
        end
    end

    // Half registers
    always_ff @(posedge clk) begin
        if (start) begin
            {l_q, r_q} <= ip_perm(plaintext);
        end else if (busy) begin
            l_q <= r_q;
            r_q <= r_next;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done);

    // A new block must wait for the previous one to finish its rounds
    assert property (@(posedge clk) disable iff (!rst_n) start |=> !start throughout last_round [->1]);

endmodule

// File: common/des_pkg.sv
package des_pkg;

    localparam int DES_ROUNDS = 8;
    localparam int RND_W      = $clog2(DES_ROUNDS + 1);
    localparam int SWEEP_BITS = 8;                        // 256 plaintexts per sweep
    localparam int SWEEP_LAST = (1 << SWEEP_BITS) - 1;

    // APB register map
    localparam logic [7:0] REG_CMD         = 8'h00;
    localparam logic [7:0] REG_STATUS      = 8'h04;
    localparam logic [7:0] REG_REGION      = 8'h08;
    localparam logic [7:0] REG_KEY_LO      = 8'h0C;
    localparam logic [7:0] REG_KEY_HI      = 8'h10;
    localparam logic [7:0] REG_MASK_IN_LO  = 8'h14;
    localparam logic [7:0] REG_MASK_IN_HI  = 8'h18;
    localparam logic [7:0] REG_MASK_OUT_LO = 8'h1C;
    localparam logic [7:0] REG_MASK_OUT_HI = 8'h20;
    localparam logic [7:0] REG_HITS        = 8'h24;
    localparam logic [7:0] REG_CT_LO       = 8'h28;
    localparam logic [7:0] REG_CT_HI       = 8'h2C;
    localparam logic [7:0] REG_COUNT       = 8'h30;

    typedef enum logic [1:0] {
        CMD_START   = 2'd0,
        CMD_TEST    = 2'd1,
        CMD_ADVANCE = 2'd2,
        CMD_RESTART = 2'd3
    } search_cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LAUNCH,
        ST_WAIT,
        ST_DONE,
        ST_TEST_LAUNCH,
        ST_TEST_WAIT,
        ST_TEST_HOLD
    } search_state_e;

    // Bit positions count from 1 at the MSB, as in the DES standard
    localparam int IP_TABLE [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam int FP_TABLE [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25
    };

    localparam int E_TABLE [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam int P_TABLE [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    // One 64-bit word per S-box row, column 0 in the top nibble
    localparam logic [63:0] SBOX_TABLE [8][4] = '{
        '{64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538, 64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D},
        '{64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5, 64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9},
        '{64'hA09E63F51DC7B428, 64'hD70934A6285ECBF1, 64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C},
        '{64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9, 64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E},
        '{64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986, 64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453},
        '{64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38, 64'h9EF528C3704A1DB6, 64'h432C95FABE17608D},
        '{64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86, 64'h14BDC37EAF680592, 64'h6BD814A7950FE23C},
        '{64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92, 64'h7B419CE206ADF358, 64'h21E74A8DFC90356B}
    };

endpackage
